// File: pq_top.f
+incdir+src
src/pq_pkg.sv
src/pq_control_fsm.sv
src/pq_index_counter.sv
src/pq_store.sv
src/pq_value_reg.sv
src/pq_top.sv
bench/pq_top_props.sv
bench/pq_top_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the priority queue testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing -f pq_top.f --top-module pq_top_tb -o pq_sim \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/pq_sim > sim.log 2>&1 ; cat sim.log
grep -q "^Verification passed$" sim.log && exit 0 || { echo "Pass line not found in sim.log"; exit 1; }

// File: bench/pq_top_tb.sv
`timescale 1ns/1ps

`include "pq_defines.svh"

module pq_top_tb;

  localparam int OP_CYCLES  = 2 * `PQ_DEPTH + 4; // Longest walk plus issue cycles
  localparam int NUM_OPS    = 320;
  localparam int MAX_CYCLES = NUM_OPS * OP_CYCLES + 200;

  logic                   clk;
  logic                   rst;
  logic                   enq;
  logic                   deq;
  logic [`PQ_ENTRY_W-1:0] enq_data;
  logic [`PQ_ENTRY_W-1:0] deq_data;
  logic                   deq_valid;
  logic                   busy;
  logic                   full;
  logic                   empty;
  logic [`PQ_CNT_W-1:0]   count;

  logic [`PQ_ENTRY_W-1:0] model [$]; // Expected contents, head first
  logic [31:0]            rng;
  logic [`PQ_TAG_W-1:0]   serial;    // Tag source, shows arrival order
  int                     errors;
  int                     deqs_expected;
  int                     deqs_seen;
  int                     cycles;
  string                  test_name;

  pq_top i_pq_top (.*);

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [`PQ_ENTRY_W-1:0] ref_head();
    return model[0];
  endfunction

  task automatic model_insert(input logic [`PQ_ENTRY_W-1:0] e);
    int pos;
    pos = 0;
    // Walk past every key that is not larger, ties stay behind
    while (pos < model.size() &&
           model[pos][`PQ_ENTRY_W-1:`PQ_TAG_W] <= e[`PQ_ENTRY_W-1:`PQ_TAG_W])
      pos++;
    model.insert(pos, e);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      errors++;
      $display("ERR %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Command drivers
  //////////////////////////////////////////////////////////////////////

  task automatic issue(input logic e, input logic d, input logic [`PQ_ENTRY_W-1:0] data,
                       input int exp_busy);
    int busy_len;
    busy_len = 0;
    @(negedge clk);
    enq      = e;
    deq      = d;
    enq_data = data;
    @(negedge clk);
    enq = 1'b0;
    deq = 1'b0;
    while (busy) // Completion marked by busy falling
    begin
      busy_len++;
      @(negedge clk);
    end
    check_value({test_name, " count"}, 32'(model.size()), 32'(count));
    check_value({test_name, " busy"}, 32'(exp_busy), 32'(busy_len));
  endtask

  task automatic push_key(input logic [`PQ_KEY_W-1:0] key);
    logic [`PQ_ENTRY_W-1:0] e;
    int                     len;
    e   = {key, serial};
    len = 0; // Dropped when full
    serial++;
    if (model.size() < `PQ_DEPTH)
    begin
      len = 2 * model.size() + 2; // Two per occupied slot, then place and finish
      model_insert(e);
    end
    issue(1'b1, 1'b0, e, len);
  endtask

  task automatic push_random();
    rng = lcg_next(rng);
    push_key({12'd0, rng[19:16]}); // Small key range, lots of ties
  endtask

  task automatic pop_head();
    int len;
    len = 0;
    if (model.size() > 0)
    begin
      deqs_expected++;
      len = 2 * model.size() + 1;
    end
    issue(1'b0, 1'b1, '0, len);
  endtask

  // Compare each dequeued entry with the model head
  always @(negedge clk)
  begin
    if (deq_valid)
    begin
      deqs_seen++;
      if (model.size() == 0)
      begin
        errors++;
        $display("Unexpected dequeue in %s while the queue should be empty", test_name);
      end
      else
      begin
        check_value(test_name, ref_head(), deq_data);
        void'(model.pop_front());
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    rst           = 1'b1;
    enq           = 1'b0;
    deq           = 1'b0;
    enq_data      = '0;
    rng           = 32'd21691;
    serial        = '0;
    errors        = 0;
    deqs_expected = 0;
    deqs_seen     = 0;
    test_name     = "reset";
    repeat (3) @(negedge clk);
    rst = 1'b0;

    test_name = "empty_deq";
    check_value({test_name, " empty"}, 32'd1, 32'(empty));
    check_value({test_name, " full"}, 32'd0, 32'(full));
    pop_head();
    repeat (4) @(negedge clk); // Window for a stray deq_valid
    check_value({test_name, " deq_valid"}, 32'd0, 32'(deqs_seen));

    test_name = "fill_drain";
    repeat (`PQ_DEPTH) push_random();
    repeat (`PQ_DEPTH) pop_head();

    test_name = "stable_order"; // Tags reveal arrival order among ties
    push_key(16'd7);
    push_key(16'd3);
    push_key(16'd7);
    push_key(16'd7);
    push_key(16'd3);
    push_key(16'd7);
    repeat (6) pop_head();

    test_name = "full_drop";
    repeat (`PQ_DEPTH) push_random();
    check_value({test_name, " full"}, 32'd1, 32'(full));
    push_key(16'd0); // Would become the head if taken
    repeat (`PQ_DEPTH) pop_head();

    test_name = "random_mix";
    repeat (200)
    begin
      rng = lcg_next(rng);
      if (model.size() == 0 || (model.size() < `PQ_DEPTH && rng[24]))
        push_random();
      else
        pop_head();
    end
    while (model.size() > 0)
      pop_head();

    test_name = "enq_deq_same";
    repeat (3) push_random();
    deqs_expected++;
    issue(1'b1, 1'b1, {16'd0, serial}, 2 * model.size() + 1); // deq wins, enq ignored
    while (model.size() > 0)
      pop_head();

    check_value("deq_total", 32'(deqs_expected), 32'(deqs_seen));
    $display("Summary: %0d errors, %0d dequeues checked", errors, deqs_seen);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

  initial
  begin
    cycles = 0;
    while (cycles < MAX_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the queue never finished the tests", cycles);
    $display("Summary: %0d errors, %0d dequeues checked", errors, deqs_seen);
    $display("Verification failed");
    $finish;
  end

endmodule

// File: bench/pq_top_props.sv
`timescale 1ns/1ps

`include "pq_defines.svh"

module pq_top_props
(
  input  logic                clk,
  input  logic                rst,
  input  logic                busy,
  input  logic                deq_valid,
  input  logic                full,
  input  logic                empty,
  input  logic [`PQ_CNT_W-1:0] count
);

  // FSM back in IDLE, no output pulse
  a_reset_quiet: assert property (@(posedge clk) rst |=> (!busy && !deq_valid))
    else $error("busy or deq_valid high after reset");

  a_count_range: assert property (@(posedge clk) disable iff (rst) count <= `PQ_DEPTH)
    else $error("count above store depth");

  a_valid_in_op: assert property (@(posedge clk) disable iff (rst) deq_valid |-> busy)
    else $error("deq_valid outside an operation");

  a_flags_apart: assert property (@(posedge clk) disable iff (rst) !(full && empty))
    else $error("full and empty high together");

endmodule

bind pq_top pq_top_props u_props
(
  .clk       (clk),
  .rst       (rst),
  .busy      (busy),
  .deq_valid (deq_valid),
  .full      (full),
  .empty     (empty),
  .count     (count)
);

// File: src/pq_top.sv
`timescale 1ns/1ps

`include "pq_defines.svh"

module pq_top import pq_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  enq,
  input  logic [`PQ_ENTRY_W-1:0] enq_data,
  input  logic                  deq,
  output logic [`PQ_ENTRY_W-1:0] deq_data,
  output logic                  deq_valid,
  output logic                  busy,
  output logic                  full,
  output logic                  empty,
  output logic [`PQ_CNT_W-1:0]   count
);

  // FSM controls
  logic     we;
  logic     wr_sel;
  logic     idx_clr;
  logic     idx_inc;
  logic     idx_peek;
  logic     cnt_inc;
  logic     cnt_dec;
  vr_mode_t mode;

  // Counter flags and datapath
  logic                   at_end;
  logic                   at_last;
  logic                   less;
  logic [`PQ_ADDR_W-1:0]  idx;
  logic [`PQ_ENTRY_W-1:0] rd_data;
  logic [`PQ_ENTRY_W-1:0] held;

  pq_control_fsm u_fsm
  (
    .clk       (clk),
    .rst       (rst),
    .enq       (enq),
    .deq       (deq),
    .full      (full),
    .empty     (empty),
    .at_end    (at_end),
    .at_last   (at_last),
    .less      (less),
    .busy      (busy),
    .we        (we),
    .wr_sel    (wr_sel),
    .idx_clr   (idx_clr),
    .idx_inc   (idx_inc),
    .idx_peek  (idx_peek),
    .cnt_inc   (cnt_inc),
    .cnt_dec   (cnt_dec),
    .deq_valid (deq_valid),
    .mode      (mode)
  );

  pq_index_counter u_cnt
  (
    .clk      (clk),
    .rst      (rst),
    .idx_clr  (idx_clr),
    .idx_inc  (idx_inc),
    .idx_peek (idx_peek),
    .cnt_inc  (cnt_inc),
    .cnt_dec  (cnt_dec),
    .idx      (idx),
    .count    (count),
    .full     (full),
    .empty    (empty),
    .at_end   (at_end),
    .at_last  (at_last)
  );

  pq_store u_store
  (
    .clk     (clk),
    .addr    (idx),
    .we      (we),
    .wr_data (held),
    .rd_data (rd_data)
  );

  pq_value_reg u_vreg
  (
    .clk      (clk),
    .rst      (rst),
    .mode     (mode),
    .wr_sel   (wr_sel),
    .enq_data (enq_data),
    .rd_data  (rd_data),
    .held     (held),
    .less     (less),
    .deq_data (deq_data)
  );

endmodule

// File: src/pq_value_reg.sv
`timescale 1ns/1ps

`include "pq_defines.svh"

module pq_value_reg import pq_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  vr_mode_t              mode,
  input  logic                  wr_sel,
  input  logic [`PQ_ENTRY_W-1:0] enq_data,
  input  logic [`PQ_ENTRY_W-1:0] rd_data,
  output logic [`PQ_ENTRY_W-1:0] held,
  output logic                  less,
  output logic [`PQ_ENTRY_W-1:0] deq_data
);

  pq_entry_u held_q; // Entry carried by the walk
  pq_entry_u rd_u;
  pq_entry_u out_q;  // Last dequeued entry

  assign rd_u = rd_data;

  //////////////////////////////////////////////////////////////////////
  // Held entry
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    case (mode)
      VR_LOAD_IN: held_q <= enq_data;
      VR_SWAP:    held_q <= rd_u;
      VR_SHIFT:   held_q <= rd_u;
      default:    held_q <= held_q;
    endcase
  end

  // Key compare only, tag is ignored
  assign less = (held_q.kv.key < rd_u.kv.key);

  // Store write data
  assign held = wr_sel ? rd_data : held_q.raw;

  //////////////////////////////////////////////////////////////////////
  // Dequeue output latch
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
      out_q.raw <= '0;
    else if (mode == VR_OUT)
      out_q <= rd_u; // Head slot read the cycle before
  end

  assign deq_data = out_q.raw;

endmodule

// File: src/pq_store.sv
`timescale 1ns/1ps

`include "pq_defines.svh"

module pq_store
(
  input  logic                  clk,
  input  logic [`PQ_ADDR_W-1:0]  addr,
  input  logic                  we,
  input  logic [`PQ_ENTRY_W-1:0] wr_data,
  output logic [`PQ_ENTRY_W-1:0] rd_data
);

  //////////////////////////////////////////////////////////////////////
  // Single-port array, block RAM style
  //////////////////////////////////////////////////////////////////////

  logic [`PQ_ENTRY_W-1:0] mem [`PQ_DEPTH];

  // Read returns the old word on a write to the same slot
  always_ff @(posedge clk)
  begin
    if (we)
      mem[addr] <= wr_data;
    rd_data <= mem[addr];
  end

endmodule

// File: src/pq_index_counter.sv
`timescale 1ns/1ps

`include "pq_defines.svh"

module pq_index_counter
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 idx_clr,
  input  logic                 idx_inc,
  input  logic                 idx_peek,
  input  logic                 cnt_inc,
  input  logic                 cnt_dec,
  output logic [`PQ_ADDR_W-1:0] idx,
  output logic [`PQ_CNT_W-1:0]  count,
  output logic                 full,
  output logic                 empty,
  output logic                 at_end,
  output logic                 at_last
);

  logic [`PQ_ADDR_W-1:0] idx_q; // Walk position
  logic [`PQ_CNT_W-1:0]  idx_ext;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      idx_q <= '0;
      count <= '0;
    end
    else
    begin
      if (idx_clr)
        idx_q <= '0;
      else if (idx_inc)
        idx_q <= idx_q + 1'b1;

      if (cnt_inc)
        count <= count + 1'b1;
      else if (cnt_dec)
        count <= count - 1'b1;
    end
  end

  // Store address, one ahead during a dequeue read
  assign idx = idx_q + {{(`PQ_ADDR_W-1){1'b0}}, idx_peek};

  assign idx_ext = {1'b0, idx_q};

  assign full    = (count == `PQ_CNT_W'(`PQ_DEPTH));
  assign empty   = (count == '0);
  assign at_end  = (idx_ext == count);
  assign at_last = (idx_ext + 1'b1 == count); // Last occupied slot

endmodule

// File: src/pq_control_fsm.sv
`timescale 1ns/1ps

module pq_control_fsm import pq_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     enq,
  input  logic     deq,
  input  logic     full,
  input  logic     empty,
  input  logic     at_end,
  input  logic     at_last,
  input  logic     less,
  output logic     busy,
  output logic     we,
  output logic     wr_sel,
  output logic     idx_clr,
  output logic     idx_inc,
  output logic     idx_peek,
  output logic     cnt_inc,
  output logic     cnt_dec,
  output logic     deq_valid,
  output vr_mode_t mode
);

  typedef enum logic [3:0]
  {
    IDLE          = 4'd0,
    ENQ_LOAD      = 4'd1,
    ENQ_READ      = 4'd2,
    ENQ_COMPARE   = 4'd3,
    ENQ_PLACE     = 4'd4,
    DEQ_READ      = 4'd5,
    DEQ_LATCH     = 4'd6,
    DEQ_READ_NEXT = 4'd7,
    DEQ_SHIFT     = 4'd8,
    FINISH        = 4'd9
  } state_t;

  state_t state;
  state_t next;
  logic   carrying; // Walk has swapped once, every later slot shifts up

  //////////////////////////////////////////////////////////////////////
  // State and flag registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= IDLE;
      carrying  <= 1'b0;
      deq_valid <= 1'b0;
    end
    else
    begin
      state     <= next;
      deq_valid <= (state == DEQ_LATCH); // deq_data is captured at this same edge
      if (state == IDLE)
        carrying <= 1'b0;
      else if (state == ENQ_COMPARE && less)
        carrying <= 1'b1;
    end
  end

  assign busy = (state != IDLE);

  //////////////////////////////////////////////////////////////////////
  // Next state and per-state controls
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    next     = state;
    we       = 1'b0;
    wr_sel   = 1'b0;
    idx_clr  = 1'b0;
    idx_inc  = 1'b0;
    idx_peek = 1'b0;
    cnt_inc  = 1'b0;
    cnt_dec  = 1'b0;
    mode     = VR_HOLD;

    case (state)
      IDLE:
      begin
        // deq has priority, enq is ignored whenever deq is raised
        if (deq)
        begin
          if (!empty)
          begin
            idx_clr = 1'b1;
            next    = DEQ_READ;
          end
        end
        else if (enq && !full)
        begin
          idx_clr = 1'b1;
          mode    = VR_LOAD_IN;
          next    = ENQ_LOAD;
        end
      end

      ENQ_LOAD:
      begin
        if (at_end) // Empty queue, new entry goes straight to slot 0
        begin
          we      = 1'b1;
          cnt_inc = 1'b1;
          next    = FINISH;
        end
        else
          next = ENQ_COMPARE; // Slot 0 read is in flight
      end

      ENQ_READ: next = ENQ_COMPARE;

      ENQ_COMPARE:
      begin
        // Equal keys only swap once a shift has started, keeping arrival order
        if (less || carrying)
        begin
          we   = 1'b1;
          mode = VR_SWAP;
        end
        idx_inc = 1'b1;
        next    = at_last ? ENQ_PLACE : ENQ_READ;
      end

      ENQ_PLACE:
      begin
        we      = 1'b1; // First free slot
        cnt_inc = 1'b1;
        next    = FINISH;
      end

      DEQ_READ: next = DEQ_LATCH;

      DEQ_LATCH:
      begin
        mode    = VR_OUT;
        cnt_dec = 1'b1; // Early, so at_last marks the final shift below
        next    = at_last ? FINISH : DEQ_READ_NEXT;
      end

      DEQ_READ_NEXT:
      begin
        idx_peek = 1'b1; // Read the slot above idx
        next     = DEQ_SHIFT;
      end

      DEQ_SHIFT:
      begin
        we      = 1'b1;
        wr_sel  = 1'b1;
        mode    = VR_SHIFT;
        idx_inc = 1'b1;
        next    = at_last ? FINISH : DEQ_READ_NEXT;
      end

      FINISH: next = IDLE;

      default: next = IDLE;
    endcase
  end

endmodule

// File: src/pq_pkg.sv
`include "pq_defines.svh"

package pq_pkg;

  // Value register load source, driven by the control FSM
  typedef enum logic [2:0]
  {
    VR_HOLD    = 3'd0, // Keep current entry
    VR_LOAD_IN = 3'd1, // Enqueue input
    VR_SWAP    = 3'd2, // Entry displaced by the walk
    VR_SHIFT   = 3'd3, // Entry moving down one slot
    VR_OUT     = 3'd4  // Head entry to dequeue output
  } vr_mode_t;

  // Key/tag view used by the comparator
  typedef struct packed
  {
    logic [`PQ_KEY_W-1:0] key;
    logic [`PQ_TAG_W-1:0] tag;
  } pq_kv_t;

  // Queue entry, seen as fields or as the raw word in the store
  typedef union packed
  {
    pq_kv_t                 kv;
    logic [`PQ_ENTRY_W-1:0] raw;
  } pq_entry_u;

endpackage

// File: src/pq_defines.svh
`ifndef PQ_DEFINES_SVH
`define PQ_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Entry layout
//////////////////////////////////////////////////////////////////////

// Priority key, compared by the enqueue walk
`define PQ_KEY_W 16

// Payload carried along with the key
`define PQ_TAG_W 16

// One stored word, key in the upper half
`define PQ_ENTRY_W (`PQ_KEY_W + `PQ_TAG_W)

//////////////////////////////////////////////////////////////////////
// Store geometry
//////////////////////////////////////////////////////////////////////

`define PQ_DEPTH 16 // Slots in the store
`define PQ_ADDR_W 4 // Slot index width

// Occupancy needs one extra bit to reach PQ_DEPTH
`define PQ_CNT_W (`PQ_ADDR_W + 1)

`endif
